//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= build.f
RTL_TOP    ?= exec_core
TB_TOP     ?= tb_exec_core
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= PASS: all tests
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- alu/alu.sv
module alu (
    input  logic [exec_pkg::xlen-1:0] src1,
    input  logic [exec_pkg::xlen-1:0] src2,
    input  exec_pkg::alu_op_t         alu_op,
    output logic [exec_pkg::xlen-1:0] alu_result
);
    import exec_pkg::*;

    logic            do_sub;
    logic [xlen-1:0] adder_b;
    logic            adder_cin;
    logic [xlen-1:0] adder_result;
    logic            adder_cout;
    logic            diff_zero;
    logic [4:0]      shamt;

    logic [xlen-1:0] add_sub_result;
    logic [xlen-1:0] sltu_result;
    logic [xlen-1:0] slt_result;
    logic [xlen-1:0] beq_result;
    logic [xlen-1:0] bne_result;
    logic [xlen-1:0] xor_result;
    logic [xlen-1:0] or_result;
    logic [xlen-1:0] and_result;
    logic [xlen-1:0] sll_result;
    logic [xlen-1:0] srl_result;
    logic [xlen-1:0] sra_result;

    // every compare reuses the subtract path
    assign do_sub = alu_op[op_sub] | alu_op[op_sltu] | alu_op[op_slt]
                  | alu_op[op_beq] | alu_op[op_bne];

    assign adder_b   = do_sub ? ~src2 : src2;
    assign adder_cin = do_sub;
    assign {adder_cout, adder_result} = {1'b0, src1} + {1'b0, adder_b}
                                      + {{xlen{1'b0}}, adder_cin};

    assign add_sub_result = adder_result;
    assign diff_zero      = ~(|adder_result);

    // no carry out of a - b means a < b unsigned
    assign sltu_result = {{(xlen-1){1'b0}}, ~adder_cout};

    // opposite signs decide directly, otherwise the difference sign does
    assign slt_result = {{(xlen-1){1'b0}},
                         (src1[xlen-1] != src2[xlen-1]) ? src1[xlen-1] : adder_result[xlen-1]};

    assign beq_result = {{(xlen-1){1'b0}}, diff_zero};
    assign bne_result = {{(xlen-1){1'b0}}, ~diff_zero};

    assign xor_result = src1 ^ src2;
    assign or_result  = src1 | src2;
    assign and_result = src1 & src2;

    assign shamt      = src2[4:0];
    assign sll_result = src1 << shamt;
    assign srl_result = src1 >> shamt;
    assign sra_result = $signed(src1) >>> shamt;

    // one-hot and-or merge
    assign alu_result = ({xlen{alu_op[op_add] | alu_op[op_sub]}} & add_sub_result)
                      | ({xlen{alu_op[op_sltu]}} & sltu_result)
                      | ({xlen{alu_op[op_bne]}}  & bne_result)
                      | ({xlen{alu_op[op_xor]}}  & xor_result)
                      | ({xlen{alu_op[op_or]}}   & or_result)
                      | ({xlen{alu_op[op_sra]}}  & sra_result)
                      | ({xlen{alu_op[op_sll]}}  & sll_result)
                      | ({xlen{alu_op[op_and]}}  & and_result)
                      | ({xlen{alu_op[op_slt]}}  & slt_result)
                      | ({xlen{alu_op[op_beq]}}  & beq_result)
                      | ({xlen{alu_op[op_srl]}}  & srl_result);

endmodule

//--- build.f
common/exec_pkg.sv
alu/alu.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/pipe_stage.sv
hdl/exec_stage.sv
hdl/exec_core.sv
test/tb_exec_core.sv

//--- common/exec_pkg.sv
package exec_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    // one-hot alu op bit positions
    localparam int op_add  = 0;
    localparam int op_sltu = 1;
    localparam int op_bne  = 2;
    localparam int op_xor  = 3;
    localparam int op_or   = 4;
    localparam int op_sub  = 5;
    localparam int op_sra  = 6;
    localparam int op_sll  = 7;
    localparam int op_and  = 8;
    localparam int op_slt  = 9;
    localparam int op_beq  = 10;
    localparam int op_srl  = 11;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // funct3 encodings shared by op and op_imm
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // funct7 values
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    typedef logic [alu_op_w-1:0] alu_op_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  use_imm;
        logic [xlen-1:0]       imm;
        logic                  writes_rd;
        logic                  is_branch;
        logic                  illegal;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
    } decoded_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic                  we;
        logic                  is_branch;
        logic                  illegal;
    } retire_t;

endpackage

//--- hdl/exec_core.sv
module exec_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    output logic              retire_valid,
    output exec_pkg::retire_t retire
);
    import exec_pkg::*;

    decoded_t        dec;
    decoded_t        dec_full;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            d2e_valid;
    decoded_t        d2e;
    retire_t         exec_result;

    instr_decoder u_instr_decoder (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (retire_valid && retire.we),
        .rd       (retire.rd),
        .wr_data  (retire.data)
    );

    // operand data joins the decoded record here
    always_comb begin
        dec_full          = dec;
        dec_full.rs1_data = rs1_data;
        dec_full.rs2_data = rs2_data;
    end

    pipe_stage #(.payload_t(decoded_t)) u_d2e (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (instr_valid),
        .in_data   (dec_full),
        .out_valid (d2e_valid),
        .out_data  (d2e)
    );

    exec_stage u_exec_stage (
        .d2e_valid (d2e_valid),
        .d2e       (d2e),
        .wb_valid  (retire_valid),
        .wb        (retire),
        .result    (exec_result)
    );

    pipe_stage #(.payload_t(retire_t)) u_e2w (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (d2e_valid),
        .in_data   (exec_result),
        .out_valid (retire_valid),
        .out_data  (retire)
    );

endmodule

//--- hdl/exec_stage.sv
module exec_stage (
    input  logic               d2e_valid,
    input  exec_pkg::decoded_t d2e,
    input  logic               wb_valid,
    input  exec_pkg::retire_t  wb,
    output exec_pkg::retire_t  result
);
    import exec_pkg::*;

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;

    // wb.we is never set for x0, so no extra rd check here
    assign fwd_rs1 = wb_valid && wb.we && (wb.rd == d2e.rs1);
    assign fwd_rs2 = wb_valid && wb.we && (wb.rd == d2e.rs2);

    assign rs1_val = fwd_rs1 ? wb.data : d2e.rs1_data;
    assign rs2_val = fwd_rs2 ? wb.data : d2e.rs2_data;

    assign src2 = d2e.use_imm ? d2e.imm : rs2_val;

    alu u_alu (
        .src1       (rs1_val),
        .src2       (src2),
        .alu_op     (d2e.alu_op),
        .alu_result (alu_result)
    );

    always_comb begin
        result           = '0;
        result.rd        = d2e.rd;
        result.data      = alu_result;
        result.we        = d2e_valid && d2e.writes_rd && !d2e.illegal && (d2e.rd != '0);
        result.is_branch = d2e.is_branch;
        result.illegal   = d2e.illegal;
    end

endmodule

//--- hdl/instr_decoder.sv
module instr_decoder (
    input  logic [31:0]        instr,
    output exec_pkg::decoded_t dec
);
    import exec_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            f7_is_base;
    logic            f7_is_alt;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    alu_op_t         op;
    logic            is_alu_fmt;

    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    assign funct7     = instr[31:25];
    assign f7_is_base = (funct7 == f7_base);
    assign f7_is_alt  = (funct7 == f7_alt);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // op stays zero for anything unsupported
    always_comb begin
        op = '0;
        case (opcode)
            opc_op: begin
                case (funct3)
                    f3_add_sub: begin
                        op[op_add] = f7_is_base;
                        op[op_sub] = f7_is_alt;
                    end
                    f3_sll:  op[op_sll]  = f7_is_base;
                    f3_slt:  op[op_slt]  = f7_is_base;
                    f3_sltu: op[op_sltu] = f7_is_base;
                    f3_xor:  op[op_xor]  = f7_is_base;
                    f3_srl_sra: begin
                        op[op_srl] = f7_is_base;
                        op[op_sra] = f7_is_alt;
                    end
                    f3_or:   op[op_or]   = f7_is_base;
                    default: op[op_and]  = f7_is_base;
                endcase
            end
            opc_op_imm: begin
                case (funct3)
                    f3_add_sub: op[op_add]  = 1'b1;
                    // shift immediates still check the upper bits
                    f3_sll:     op[op_sll]  = f7_is_base;
                    f3_slt:     op[op_slt]  = 1'b1;
                    f3_sltu:    op[op_sltu] = 1'b1;
                    f3_xor:     op[op_xor]  = 1'b1;
                    f3_srl_sra: begin
                        op[op_srl] = f7_is_base;
                        op[op_sra] = f7_is_alt;
                    end
                    f3_or:      op[op_or]   = 1'b1;
                    default:    op[op_and]  = 1'b1;
                endcase
            end
            opc_branch: begin
                op[op_beq] = (funct3 == f3_beq);
                op[op_bne] = (funct3 == f3_bne);
            end
            default: op = '0;
        endcase
    end

    assign is_alu_fmt = (opcode == opc_op) || (opcode == opc_op_imm);

    always_comb begin
        dec           = '0;
        dec.alu_op    = op;
        dec.rd        = instr[11:7];
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.use_imm   = (opcode == opc_op_imm);
        dec.imm       = (opcode == opc_branch) ? imm_b : imm_i;
        dec.writes_rd = is_alu_fmt && (op != '0);
        dec.is_branch = (opcode == opc_branch) && (op != '0);
        dec.illegal   = (op == '0);
    end

endmodule

//--- hdl/pipe_stage.sv
module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload only moves with a valid beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

//--- hdl/reg_file.sv
module reg_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [exec_pkg::reg_addr_w-1:0] rs1,
    input  logic [exec_pkg::reg_addr_w-1:0] rs2,
    output logic [exec_pkg::xlen-1:0]       rs1_data,
    output logic [exec_pkg::xlen-1:0]       rs2_data,
    input  logic                            we,
    input  logic [exec_pkg::reg_addr_w-1:0] rd,
    input  logic [exec_pkg::xlen-1:0]       wr_data
);
    import exec_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wr_data;
        end
    end

    // write-through so a same-cycle write is visible
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        logic [xlen-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (we && (addr == rd)) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

//--- test/exec_vectors.txt
# columns: instr gap rd data we is_branch illegal
# instr and data in hex, the others decimal; gap is idle cycles after the word
# untouched registers read zero
007302b3 3  5 00000000 1 0 0
# operands through forwarding and write-through
00500093 0  1 00000005 1 0 0
ffd00113 0  2 fffffffd 1 0 0
002081b3 0  3 00000002 1 0 0
40110233 0  4 fffffff8 1 0 0
00112333 0  6 00000001 1 0 0
001133b3 0  7 00000000 1 0 0
0020a433 0  8 00000000 1 0 0
0020b4b3 0  9 00000001 1 0 0
# add and sub wrap
fff00513 0 10 ffffffff 1 0 0
00150593 0 11 00000000 1 0 0
40100633 2 12 fffffffb 1 0 0
# logic ops and immediate compares
0020c6b3 0 13 fffffff8 1 0 0
0020e733 0 14 fffffffd 1 0 0
0020f7b3 0 15 00000005 1 0 0
0f00c813 0 16 000000f5 1 0 0
ff00e893 0 17 fffffff5 1 0 0
07f17913 0 18 0000007d 1 0 0
00112993 0 19 00000001 1 0 0
fff0ba13 4 20 00000001 1 0 0
# shifts use the low five bits
01f09a93 0 21 80000000 1 0 0
00415b13 0 22 0fffffff 1 0 0
40115b93 0 23 fffffffe 1 0 0
01609c33 0 24 80000000 1 0 0
401adcb3 0 25 fc000000 1 0 0
001add33 0 26 04000000 1 0 0
# branch compares
00f08063 0  0 00000001 0 1 0
00f09063 0  0 00000000 0 1 0
00209063 0  0 00000001 0 1 0
00058063 0  0 00000001 0 1 0
# x0 stays zero
00708013 0  0 0000000c 0 0 0
00000db3 1 27 00000000 1 0 0
# illegal words leave x1 alone
00012083 0  1 00000000 0 0 1
4020f0b3 0  1 00000000 0 0 1
2010d093 0  1 00000000 0 0 1
0000a063 0  0 00000000 0 0 1
00008e33 0 28 00000005 1 0 0
# dense dependent chain
001e0e93 0 29 00000006 1 0 0
01de8f33 0 30 0000000c 1 0 0
41df0fb3 0 31 00000006 1 0 0

//--- test/tb_exec_core.sv
module tb_exec_core;
    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam string vector_file = "test/exec_vectors.txt";
    localparam int    drain_limit = 50;

    typedef struct packed {
        logic [31:0] instr;
        int          cycle;
        retire_t     rec;
    } exp_entry_t;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] vec_instr[$];
    int          vec_gap[$];
    retire_t     vec_expect[$];
    exp_entry_t  expected_q[$];

    int cycle_count     = 0;
    int check_errors    = 0;
    int protocol_errors = 0;
    int other_errors    = 0;
    bit timed_out       = 1'b0;

    exec_core u_exec_core (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] word;
        logic [31:0] data;
        int          gap;
        int          rd_i;
        int          we_i;
        int          br_i;
        int          ill_i;
        retire_t     rec;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            $display("could not open %s", vector_file);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // blank lines and comment lines carry no vector
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %d %d %h %d %d %d",
                                word, gap, rd_i, data, we_i, br_i, ill_i);
                    if (n == 7) begin
                        rec.rd        = rd_i[4:0];
                        rec.data      = data;
                        rec.we        = we_i[0];
                        rec.is_branch = br_i[0];
                        rec.illegal   = ill_i[0];
                        vec_instr.push_back(word);
                        vec_gap.push_back(gap);
                        vec_expect.push_back(rec);
                    end else begin
                        other_errors++;
                        $display("malformed vector line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        reset       <= 1'b1;
        instr_valid <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic drive_vector(input int idx, input bit random_gaps);
        exp_entry_t entry;
        int         idle;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= vec_instr[idx];
        // counter still holds the cycle before this edge
        entry.instr = vec_instr[idx];
        entry.cycle = cycle_count + 3;
        entry.rec   = vec_expect[idx];
        expected_q.push_back(entry);
        idle = vec_gap[idx];
        if (random_gaps && idle == 0) begin
            idle = $urandom % 3;
        end
        repeat (idle) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            timed_out = 1'b1;
            other_errors++;
            $display("timeout: %0d instructions never retired within %0d cycles",
                     expected_q.size(), drain_limit);
        end
    endtask

    task automatic run_pass(input bit random_gaps);
        for (int i = 0; i < vec_instr.size(); i++) begin
            drive_vector(i, random_gaps);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        wait_drain();
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // sampled mid-cycle, away from the edge where the outputs move
    always @(negedge clk) begin : retire_monitor
        exp_entry_t head;
        logic       late;
        if (!reset) begin
            late = (expected_q.size() != 0) && (expected_q[0].cycle < cycle_count);
            assert (!late) else begin
                protocol_errors++;
                $display("t=%0t: instruction %h did not retire 2 cycles after it was presented",
                         $time, expected_q[0].instr);
            end
            if (late) begin
                void'(expected_q.pop_front());
            end
            if (retire_valid) begin
                assert (expected_q.size() != 0) else begin
                    protocol_errors++;
                    $display("t=%0t: retire_valid high with no instruction in flight", $time);
                end
                if (expected_q.size() != 0) begin
                    head = expected_q.pop_front();
                    assert (head.cycle == cycle_count) else begin
                        protocol_errors++;
                        $display("t=%0t: instruction %h retired in cycle %0d instead of %0d",
                                 $time, head.instr, cycle_count, head.cycle);
                    end
                    check_field("retire.rd", 32'(head.rec.rd), 32'(retire.rd));
                    check_field("retire.data", head.rec.data, retire.data);
                    check_field("retire.we", 32'(head.rec.we), 32'(retire.we));
                    check_field("retire.is_branch", 32'(head.rec.is_branch),
                                32'(retire.is_branch));
                    check_field("retire.illegal", 32'(head.rec.illegal), 32'(retire.illegal));
                end
            end
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        void'($urandom(32'h2823_54da));
        load_vectors();
        if (vec_instr.size() == 0) begin
            other_errors++;
            $display("no vectors were loaded from %s", vector_file);
        end else begin
            // first pass dense as listed, second with random idle cycles
            for (int pass = 0; pass < 2 && !timed_out; pass++) begin
                apply_reset();
                run_pass(pass == 1);
            end
        end
        $display("errors: %0d check, %0d protocol, %0d other",
                 check_errors, protocol_errors, other_errors);
        if (check_errors + protocol_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
